// File: vlog.f
+incdir+hw
hw/rat_pkg.sv
hw/rat_wb_match.sv
hw/rat_lookup.sv
hw/rat_state.sv
hw/rename_map_top.sv
sim/rat_chk.sv
sim/rat_tb.sv

// File: sim/rat_tb.sv
`default_nettype none

`include "rat_settings.svh"

module rat_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 5;

    // ==================================================================
    // DUT signals
    // ==================================================================

    logic clock;
    logic reset;
    rat_pkg::arch_idx_t rs1_arch;
    rat_pkg::arch_idx_t rs2_arch;
    rat_pkg::phys_tag_t rs1_phys;
    rat_pkg::phys_tag_t rs2_phys;
    logic rs1_ready;
    logic rs2_ready;
    logic disp_valid;
    rat_pkg::arch_idx_t disp_arch;
    rat_pkg::phys_tag_t disp_new_phys;
    rat_pkg::phys_tag_t disp_old_phys;
    logic is_branch;
    logic [`RAT_WB_PORTS-1:0] wb_valid;
    rat_pkg::wb_tags_t wb_phys;
    logic snapshot_restore;
    rat_pkg::map_table_t snapshot_in;
    rat_pkg::map_table_t snapshot_out;
    logic snapshot_valid;

    // reference table and bookkeeping
    rat_pkg::map_table_t model;
    integer seed;
    int errors;
    int checks;
    int tests_run;
    int test_errors_at_start;
    string cur_test;

    rename_map_top uut (
        .clock              (clock),
        .reset              (reset),
        .rs1_arch_i         (rs1_arch),
        .rs2_arch_i         (rs2_arch),
        .rs1_phys_o         (rs1_phys),
        .rs1_ready_o        (rs1_ready),
        .rs2_phys_o         (rs2_phys),
        .rs2_ready_o        (rs2_ready),
        .disp_valid_i       (disp_valid),
        .disp_arch_i        (disp_arch),
        .disp_new_phys_i    (disp_new_phys),
        .disp_old_phys_o    (disp_old_phys),
        .is_branch_i        (is_branch),
        .wb_valid_i         (wb_valid),
        .wb_phys_i          (wb_phys),
        .snapshot_restore_i (snapshot_restore),
        .snapshot_data_i    (snapshot_in),
        .snapshot_data_o    (snapshot_out),
        .snapshot_valid_o   (snapshot_valid)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // watchdog allows 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * 20);
        $display("timeout: the tests did not complete in the allowed time");
        $display("Testbench failed");
        $finish;
    end

    // ==================================================================
    // reference model
    // ==================================================================

    // entries whose current tag matches a valid writeback port
    function automatic logic [`RAT_ARCH_REGS-1:0] wb_hits();
        logic [`RAT_ARCH_REGS-1:0] hit;
        hit = '0;
        for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
            for (int p = 0; p < `RAT_WB_PORTS; p++) begin
                if (wb_valid[p] && (model[i].tag == wb_phys[p])) begin
                    hit[i] = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // model table with the driven rename overlaid on any register but 0
    function automatic rat_pkg::map_table_t overlay_rename();
        rat_pkg::map_table_t t;
        t = model;
        if (disp_valid && (disp_arch != rat_pkg::arch_idx_t'(`RAT_ZERO_REG))) begin
            t[disp_arch].tag = disp_new_phys;
            t[disp_arch].ready = 1'b0;
        end
        return t;
    endfunction

    // table after the coming edge
    function automatic rat_pkg::map_table_t next_model();
        rat_pkg::map_table_t nxt;
        logic [`RAT_ARCH_REGS-1:0] hit;
        logic renamed;
        hit = wb_hits();
        nxt = overlay_rename();
        for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
            renamed = disp_valid && (disp_arch == i) && (i != `RAT_ZERO_REG);
            if (snapshot_restore) begin
                nxt[i].tag = snapshot_in[i].tag;
                nxt[i].ready = snapshot_in[i].ready ||
                    ((snapshot_in[i].tag == model[i].tag) && (model[i].ready || hit[i]));
            end else if (hit[i] && !renamed) begin
                nxt[i].ready = 1'b1;
            end
        end
        return nxt;
    endfunction

    // ==================================================================
    // compare tasks and helpers
    // ==================================================================

    task automatic compare_tag(string what, rat_pkg::phys_tag_t exp, rat_pkg::phys_tag_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected=%0d actual=%0d", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_ready(string what, bit exp, bit act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected=%0b actual=%0b", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_table(string what, rat_pkg::map_table_t exp,
                                 rat_pkg::map_table_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected=%h actual=%h", cur_test, what, exp, act);
        end
    endtask

    // advance one edge, then land 2 ns after it
    task automatic step();
        rat_pkg::map_table_t nxt;
        nxt = next_model();
        @(posedge clock);
        model = nxt;
        #2;
    endtask

    task automatic clear_strobes();
        disp_valid = 1'b0;
        is_branch = 1'b0;
        wb_valid = '0;
        snapshot_restore = 1'b0;
    endtask

    // both source ports against the model including forwarding
    task automatic check_sources();
        logic [`RAT_ARCH_REGS-1:0] hit;
        hit = wb_hits();
        compare_tag("rs1 tag", model[rs1_arch].tag, rs1_phys);
        compare_ready("rs1 ready", model[rs1_arch].ready | hit[rs1_arch], rs1_ready);
        compare_tag("rs2 tag", model[rs2_arch].tag, rs2_phys);
        compare_ready("rs2 ready", model[rs2_arch].ready | hit[rs2_arch], rs2_ready);
    endtask

    task automatic rename(rat_pkg::arch_idx_t arch, rat_pkg::phys_tag_t tag);
        disp_valid = 1'b1;
        disp_arch = arch;
        disp_new_phys = tag;
        #1;
        compare_tag("old tag", model[arch].tag, disp_old_phys);
        step();
        clear_strobes();
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        test_errors_at_start = errors;
        clear_strobes();
    endtask

    task automatic end_test();
        // with no rename pending the snapshot port shows the stored table
        #1;
        compare_table("table", model, snapshot_out);
        tests_run++;
        $display("test %s finished with %0d errors", cur_test, errors - test_errors_at_start);
        step();
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================

    task automatic test_reset_lookup();
        begin_test("reset_lookup");
        for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
            rs1_arch = rat_pkg::arch_idx_t'(i);
            rs2_arch = rat_pkg::arch_idx_t'(`RAT_ARCH_REGS - 1 - i);
            #1;
            // identity map straight from the reset rule
            compare_tag("rs1 tag", rat_pkg::phys_tag_t'(i), rs1_phys);
            compare_ready("rs1 ready", 1'b1, rs1_ready);
            compare_tag("rs2 tag", rat_pkg::phys_tag_t'(`RAT_ARCH_REGS - 1 - i), rs2_phys);
            compare_ready("rs2 ready", 1'b1, rs2_ready);
            step();
        end
        end_test();
    endtask

    task automatic test_random_rename();
        rat_pkg::arch_idx_t arch;
        begin_test("random_rename");
        for (int n = 0; n < 40; n++) begin
            // first pass hits register zero on purpose
            arch = (n == 0) ? rat_pkg::arch_idx_t'(`RAT_ZERO_REG) :
                              rat_pkg::arch_idx_t'($random(seed));
            rename(arch, rat_pkg::phys_tag_t'($random(seed)));
            rs1_arch = arch;
            rs2_arch = rat_pkg::arch_idx_t'($random(seed));
            #1;
            check_sources();
            step();
        end
        end_test();
    endtask

    task automatic test_writeback();
        begin_test("writeback");
        rename(5'd5, 6'd40);
        // single port forwarded then stored
        wb_valid = 2'b01;
        wb_phys[0] = 6'd40;
        rs1_arch = 5'd5;
        #1;
        check_sources();
        step();
        clear_strobes();
        #1;
        check_sources();
        step();
        // both ports in one cycle
        rename(5'd12, 6'd42);
        rename(5'd13, 6'd43);
        wb_valid = 2'b11;
        wb_phys[0] = 6'd42;
        wb_phys[1] = 6'd43;
        rs1_arch = 5'd12;
        rs2_arch = 5'd13;
        #1;
        check_sources();
        step();
        clear_strobes();
        #1;
        check_sources();
        step();
        // writeback of the tag being displaced in the same cycle
        rename(5'd20, 6'd44);
        wb_valid = 2'b01;
        wb_phys[0] = 6'd44;
        rename(5'd20, 6'd45);
        rs1_arch = 5'd20;
        #1;
        check_sources();
        step();
        end_test();
    endtask

    task automatic test_snapshot_out();
        begin_test("snapshot_out");
        for (int n = 0; n < 20; n++) begin
            is_branch = $random(seed);
            disp_valid = $random(seed);
            disp_arch = rat_pkg::arch_idx_t'($random(seed));
            disp_new_phys = rat_pkg::phys_tag_t'($random(seed));
            #1;
            compare_ready("snapshot valid", is_branch, snapshot_valid);
            compare_table("snapshot data", overlay_rename(), snapshot_out);
            step();
        end
        clear_strobes();
        end_test();
    endtask

    task automatic test_restore();
        rat_pkg::map_table_t captured;
        begin_test("restore");
        rename(5'd8, 6'd55);
        // branch renaming r7 with the checkpoint taken from the model
        is_branch = 1'b1;
        disp_valid = 1'b1;
        disp_arch = 5'd7;
        disp_new_phys = 6'd50;
        captured = overlay_rename();
        #1;
        compare_table("captured snapshot", captured, snapshot_out);
        step();
        clear_strobes();
        // r3 moves off its checkpoint tag so the two old tag sources differ
        rename(5'd3, ~captured[3].tag);
        rename(5'd9, 6'd54);
        // r7 turns ready after the checkpoint
        wb_valid = 2'b01;
        wb_phys[0] = 6'd50;
        step();
        clear_strobes();
        // restore with a competing rename and a writeback of r8's tag
        snapshot_restore = 1'b1;
        snapshot_in = captured;
        disp_valid = 1'b1;
        disp_arch = 5'd3;
        disp_new_phys = 6'd60;
        wb_valid = 2'b01;
        wb_phys[0] = 6'd55;
        #1;
        compare_tag("old tag from snapshot", captured[3].tag, disp_old_phys);
        step();
        clear_strobes();
        rs1_arch = 5'd7;
        rs2_arch = 5'd8;
        #1;
        check_sources();
        step();
        end_test();
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        seed = 21;
        errors = 0;
        checks = 0;
        tests_run = 0;
        reset = 1'b1;
        rs1_arch = '0;
        rs2_arch = '0;
        disp_valid = 1'b0;
        disp_arch = '0;
        disp_new_phys = '0;
        is_branch = 1'b0;
        wb_valid = '0;
        wb_phys = '0;
        snapshot_restore = 1'b0;
        snapshot_in = '0;
        for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
            model[i].tag = rat_pkg::phys_tag_t'(i);
            model[i].ready = 1'b1;
        end
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;

        test_reset_lookup();
        test_random_rename();
        test_writeback();
        test_snapshot_out();
        test_restore();

        // failed assertions in the bound checker count as errors
        errors += uut.u_state.u_chk.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rat_chk.sv
`default_nettype none

`include "rat_settings.svh"

module rat_chk (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 disp_valid_i,
    input  wire rat_pkg::arch_idx_t   disp_arch_i,
    input  wire rat_pkg::phys_tag_t   disp_new_phys_i,
    input  wire logic                 snapshot_restore_i,
    input  wire rat_pkg::map_table_t  cur_table_i,
    input  wire rat_pkg::map_table_t  snap_data_i,
    input  wire logic                 snapshot_valid_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions counted for the testbench summary
    int fail_count = 0;

    // a raised checkpoint carries the branch slot's own rename
    snap_rename_a: assert property (@(posedge clock) disable iff (reset)
        (snapshot_valid_i && disp_valid_i &&
         (disp_arch_i != rat_pkg::arch_idx_t'(`RAT_ZERO_REG)))
        |-> (snap_data_i[disp_arch_i].tag == disp_new_phys_i) &&
            !snap_data_i[disp_arch_i].ready)
        else begin
            $error("checkpoint does not hold the branch rename");
            fail_count++;
        end

    // a live rename lands with the new tag, not ready, one cycle later
    rename_lands_a: assert property (@(posedge clock) disable iff (reset)
        (disp_valid_i && !snapshot_restore_i &&
         (disp_arch_i != rat_pkg::arch_idx_t'(`RAT_ZERO_REG)))
        |=> (cur_table_i[$past(disp_arch_i)].tag == $past(disp_new_phys_i)) &&
            !cur_table_i[$past(disp_arch_i)].ready)
        else begin
            $error("renamed entry does not hold the new tag as not ready");
            fail_count++;
        end

    // zero register keeps its identity mapping
    zero_reg_a: assert property (@(posedge clock) disable iff (reset)
        cur_table_i[`RAT_ZERO_REG].tag == rat_pkg::phys_tag_t'(0))
        else begin
            $error("zero register entry lost tag 0");
            fail_count++;
        end

endmodule

// attached to every rat_state instance
bind rat_state rat_chk u_chk (
    .clock              (clock),
    .reset              (reset),
    .disp_valid_i       (disp_valid_i),
    .disp_arch_i        (disp_arch_i),
    .disp_new_phys_i    (disp_new_phys_i),
    .snapshot_restore_i (snapshot_restore_i),
    .cur_table_i        (cur_table_o),
    .snap_data_i        (snapshot_data_o),
    .snapshot_valid_i   (snapshot_valid_o)
);

`default_nettype wire

// File: hw/rename_map_top.sv
`default_nettype none

`include "rat_settings.svh"

module rename_map_top (
    input  logic                          clock,
    input  logic                          reset,

    // source lookups
    input  rat_pkg::arch_idx_t            rs1_arch_i,
    input  rat_pkg::arch_idx_t            rs2_arch_i,
    output rat_pkg::phys_tag_t            rs1_phys_o,
    output logic                          rs1_ready_o,
    output rat_pkg::phys_tag_t            rs2_phys_o,
    output logic                          rs2_ready_o,

    // destination rename
    input  logic                          disp_valid_i,
    input  rat_pkg::arch_idx_t            disp_arch_i,
    input  rat_pkg::phys_tag_t            disp_new_phys_i,
    output rat_pkg::phys_tag_t            disp_old_phys_o,
    input  logic                          is_branch_i,

    // writeback
    input  logic [`RAT_WB_PORTS-1:0]      wb_valid_i,
    input  rat_pkg::wb_tags_t             wb_phys_i,

    // snapshot save and restore
    input  logic                          snapshot_restore_i,
    input  rat_pkg::map_table_t           snapshot_data_i,
    output rat_pkg::map_table_t           snapshot_data_o,
    output logic                          snapshot_valid_o
);

    // ==================================================================
    // internal nets
    // ==================================================================

    // registered table from the state block
    rat_pkg::map_table_t           cur_table;
    // entries matched by a writeback this cycle
    logic [`RAT_ARCH_REGS-1:0]     wb_hit;

    // writeback tag compare, shared by lookup and state
    rat_wb_match u_wb_match (
        .cur_table_i        (cur_table),
        .wb_valid_i         (wb_valid_i),
        .wb_phys_i          (wb_phys_i),
        .wb_hit_o           (wb_hit)
    );

    // combinational read ports
    rat_lookup u_lookup (
        .cur_table_i        (cur_table),
        .wb_hit_i           (wb_hit),
        .rs1_arch_i         (rs1_arch_i),
        .rs2_arch_i         (rs2_arch_i),
        .disp_arch_i        (disp_arch_i),
        .snapshot_restore_i (snapshot_restore_i),
        .snapshot_data_i    (snapshot_data_i),
        .rs1_phys_o         (rs1_phys_o),
        .rs1_ready_o        (rs1_ready_o),
        .rs2_phys_o         (rs2_phys_o),
        .rs2_ready_o        (rs2_ready_o),
        .disp_old_phys_o    (disp_old_phys_o)
    );

    // table registers and update rules
    rat_state u_state (
        .clock              (clock),
        .reset              (reset),
        .wb_hit_i           (wb_hit),
        .disp_valid_i       (disp_valid_i),
        .disp_arch_i        (disp_arch_i),
        .disp_new_phys_i    (disp_new_phys_i),
        .is_branch_i        (is_branch_i),
        .snapshot_restore_i (snapshot_restore_i),
        .snapshot_data_i    (snapshot_data_i),
        .cur_table_o        (cur_table),
        .snapshot_data_o    (snapshot_data_o),
        .snapshot_valid_o   (snapshot_valid_o)
    );

endmodule

`default_nettype wire

// File: hw/rat_state.sv
`default_nettype none

`include "rat_settings.svh"

module rat_state (
    input  logic                          clock,
    input  logic                          reset,

    // entries whose tag is written back this cycle
    input  logic [`RAT_ARCH_REGS-1:0]     wb_hit_i,

    // dispatch slot
    input  logic                          disp_valid_i,
    input  rat_pkg::arch_idx_t            disp_arch_i,
    input  rat_pkg::phys_tag_t            disp_new_phys_i,
    input  logic                          is_branch_i,

    // restore path
    input  logic                          snapshot_restore_i,
    input  rat_pkg::map_table_t           snapshot_data_i,

    // table as held now
    output rat_pkg::map_table_t           cur_table_o,

    // checkpoint taken at dispatch
    output rat_pkg::map_table_t           snapshot_data_o,
    output logic                          snapshot_valid_o
);

    // ==================================================================
    // state
    // ==================================================================

    // registered table and its next value
    rat_pkg::map_table_t table_q;
    rat_pkg::map_table_t table_d;

    // table with this cycle's rename applied, restore ignored
    rat_pkg::map_table_t renamed_table;

    // rename that really writes an entry
    logic rename_en;
    // one-hot entry written by the rename
    logic [`RAT_ARCH_REGS-1:0] rename_sel;

    assign cur_table_o = table_q;

    // ==================================================================
    // dispatch rename
    // ==================================================================

    // register zero keeps its mapping whatever the dispatch says
    assign rename_en = disp_valid_i &&
                       (disp_arch_i != rat_pkg::arch_idx_t'(`RAT_ZERO_REG));

    always_comb begin
        for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
            rename_sel[i] = rename_en && (disp_arch_i == rat_pkg::arch_idx_t'(i));
        end
    end

    // new tag goes in not ready, its producer has not written back yet
    always_comb begin
        renamed_table = table_q;
        for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
            if (rename_sel[i]) begin
                renamed_table[i].tag   = disp_new_phys_i;
                renamed_table[i].ready = 1'b0;
            end
        end
    end

    // ==================================================================
    // next state
    // ==================================================================

    always_comb begin
        table_d = renamed_table;
        if (snapshot_restore_i) begin
            // restore wins over the rename of the same cycle
            for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
                table_d[i].tag = snapshot_data_i[i].tag;
                // a snapshot entry may be stale on readiness;
                // if the tag survives the restore, keep what the live entry knows,
                // including a writeback landing right now
                table_d[i].ready = snapshot_data_i[i].ready ||
                                   ((snapshot_data_i[i].tag == table_q[i].tag) &&
                                    (table_q[i].ready || wb_hit_i[i]));
            end
        end else begin
            // writeback marks every entry holding the tag,
            // except the one just renamed, which now holds a new tag
            for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
                if (wb_hit_i[i] && !rename_sel[i]) begin
                    table_d[i].ready = 1'b1;
                end
            end
        end
    end

    // identity map on reset, every tag ready
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RAT_ARCH_REGS; i++) begin
                table_q[i].tag   <= rat_pkg::phys_tag_t'(i);
                table_q[i].ready <= 1'b1;
            end
        end else begin
            table_q <= table_d;
        end
    end

    // ==================================================================
    // snapshot output
    // ==================================================================

    // the checkpoint must include the branch slot's own rename,
    // so it reflects state right after this dispatch
    assign snapshot_data_o = renamed_table;

    // single dispatch slot, the flag is simply the branch bit
    assign snapshot_valid_o = is_branch_i;

endmodule

`default_nettype wire

// File: hw/rat_lookup.sv
`default_nettype none

`include "rat_settings.svh"

module rat_lookup (
    // table and writeback hits from this cycle
    input  rat_pkg::map_table_t           cur_table_i,
    input  logic [`RAT_ARCH_REGS-1:0]     wb_hit_i,

    // source and destination indices
    input  rat_pkg::arch_idx_t            rs1_arch_i,
    input  rat_pkg::arch_idx_t            rs2_arch_i,
    input  rat_pkg::arch_idx_t            disp_arch_i,

    // restore path
    input  logic                          snapshot_restore_i,
    input  rat_pkg::map_table_t           snapshot_data_i,

    // source results
    output rat_pkg::phys_tag_t            rs1_phys_o,
    output logic                          rs1_ready_o,
    output rat_pkg::phys_tag_t            rs2_phys_o,
    output logic                          rs2_ready_o,

    // tag displaced by the destination rename
    output rat_pkg::phys_tag_t            disp_old_phys_o
);

    // ==================================================================
    // source operand reads
    // ==================================================================

    // selected entries
    rat_pkg::map_entry_t rs1_entry;
    rat_pkg::map_entry_t rs2_entry;

    assign rs1_entry = cur_table_i[rs1_arch_i];
    assign rs2_entry = cur_table_i[rs2_arch_i];

    assign rs1_phys_o = rs1_entry.tag;
    assign rs2_phys_o = rs2_entry.tag;

    // stored ready or a writeback of the same tag in this cycle
    // so a consumer dispatched alongside the producer's writeback
    // does not wait an extra cycle
    assign rs1_ready_o = rs1_entry.ready | wb_hit_i[rs1_arch_i];
    assign rs2_ready_o = rs2_entry.ready | wb_hit_i[rs2_arch_i];

    // ==================================================================
    // destination old tag
    // ==================================================================

    // old tag as the table holds it now
    rat_pkg::phys_tag_t table_old_tag;
    // old tag as the incoming snapshot holds it
    rat_pkg::phys_tag_t snap_old_tag;

    assign table_old_tag = cur_table_i[disp_arch_i].tag;
    assign snap_old_tag  = snapshot_data_i[disp_arch_i].tag;

    // during a restore the snapshot is the state being returned to,
    // so the old tag is taken from it and not from the table
    assign disp_old_phys_o = snapshot_restore_i ? snap_old_tag : table_old_tag;

endmodule

`default_nettype wire

// File: hw/rat_wb_match.sv
`default_nettype none

`include "rat_settings.svh"

module rat_wb_match (
    // current table contents
    input  rat_pkg::map_table_t           cur_table_i,

    // writeback ports
    input  logic [`RAT_WB_PORTS-1:0]      wb_valid_i,
    input  rat_pkg::wb_tags_t             wb_phys_i,

    // one bit per architectural register whose tag was written back
    output logic [`RAT_ARCH_REGS-1:0]     wb_hit_o
);

    // ==================================================================
    // comparator bank
    // ==================================================================

    // per port, per entry match
    logic [`RAT_WB_PORTS-1:0][`RAT_ARCH_REGS-1:0] port_hit;

    // every valid port is compared against every entry tag
    // several entries can share a tag after a restore, so all of them hit
    for (genvar p = 0; p < `RAT_WB_PORTS; p++) begin : g_port
        for (genvar j = 0; j < `RAT_ARCH_REGS; j++) begin : g_entry
            assign port_hit[p][j] = wb_valid_i[p] &&
                                    (cur_table_i[j].tag == wb_phys_i[p]);
        end
    end

    // ==================================================================
    // merge across ports
    // ==================================================================

    // any port hitting an entry marks it
    // two ports may carry different tags in one cycle, both count
    always_comb begin
        wb_hit_o = '0;
        for (int p = 0; p < `RAT_WB_PORTS; p++) begin
            wb_hit_o = wb_hit_o | port_hit[p];
        end
    end

    // the same hit vector feeds the lookup forwarding
    // and the stored ready update in the state block

endmodule

`default_nettype wire

// File: hw/rat_pkg.sv
`default_nettype none

`include "rat_settings.svh"

package rat_pkg;

    // ==================================================================
    // index and tag types
    // ==================================================================

    // architectural register index, sized from the register count
    typedef logic [$clog2(`RAT_ARCH_REGS)-1:0] arch_idx_t;

    // physical register tag, sized from the tag count
    typedef logic [$clog2(`RAT_PHYS_REGS)-1:0] phys_tag_t;

    // ==================================================================
    // table types
    // ==================================================================

    // one mapping entry
    // ready means the value behind the tag has been written back
    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
    } map_entry_t;

    // whole table, entry i maps architectural register i
    // this is also the word saved and restored as a branch snapshot
    typedef map_entry_t [`RAT_ARCH_REGS-1:0] map_table_t;

    // tags presented on the writeback ports, one per port
    typedef phys_tag_t [`RAT_WB_PORTS-1:0] wb_tags_t;

endpackage

`default_nettype wire

// File: hw/rat_settings.svh
`ifndef RAT_SETTINGS_SVH
`define RAT_SETTINGS_SVH

// ======================================================================
// register alias table sizing
// ======================================================================

// architectural registers visible to software
`define RAT_ARCH_REGS 32

// physical tags handed out by the free list
// must be at least RAT_ARCH_REGS so the identity reset map is legal
`define RAT_PHYS_REGS 64

// ======================================================================
// port counts
// ======================================================================

// writeback ports from the execution units, each a one-cycle valid
`define RAT_WB_PORTS 2

// ======================================================================
// special registers
// ======================================================================

// hardwired zero register, never renamed
// its entry keeps tag 0 and stays ready
`define RAT_ZERO_REG 0

`endif
